// ==== source/imem_bus_pkg.sv ====
`default_nettype none

package imem_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // RV32 only
  localparam int XLEN = 32;

  // Instruction address, one word
  typedef logic [XLEN-1:0] addr_t;

  // Wishbone read data, one word
  typedef logic [XLEN-1:0] word_t;

  ////////////////////////////////////////////////////////////////////////////
  // Attribute regions
  ////////////////////////////////////////////////////////////////////////////

  // Number of base/mask/exec triples
  localparam int REGION_CNT = 2;

  // No compressed parcels, so every fetch is a full word
  // Low PC bits must be zero
  localparam int WORD_ALIGN_BITS = 2;

endpackage

`default_nettype wire

// ==== source/imem_fetch_pkg.sv ====
`default_nettype none

package imem_fetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Parcel record
  ////////////////////////////////////////////////////////////////////////////

  // One queued fetch result as seen by the CPU
  typedef struct packed {
    imem_bus_pkg::addr_t pc;          // PC of this parcel
    imem_bus_pkg::word_t insn;        // Instruction word, zero on any fault
    logic                misaligned;  // Low PC bits nonzero
    logic                error;       // Region, exec or bus fault
  } parcel_t;

  ////////////////////////////////////////////////////////////////////////////
  // Queue sizing
  ////////////////////////////////////////////////////////////////////////////

  // Next-PC buffer
  localparam int PC_BUF_DEPTH = 2;

  // Parcel queue, with headroom past the stall point
  localparam int PARCEL_Q_DEPTH = 8;

  // Stall threshold
  // Leaves room for buffered PCs plus the one on the bus
  localparam int PARCEL_Q_ALMOST_FULL = 4;

endpackage

`default_nettype wire

// ==== source/imem_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_fifo #(
  parameter type payload_t   = logic [31:0],
  parameter int  DEPTH       = 2,
  parameter int  ALMOST_FULL = DEPTH
)
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     clr_i,          // Synchronous flush
  input  logic     we_i,
  input  logic     re_i,
  input  payload_t d_i,
  output payload_t q_o,            // Head, shown combinationally
  output logic     empty_o,
  output logic     full_o,
  output logic     almost_full_o
);

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  payload_t mem [DEPTH];           // Storage array

  ptr_t wr_ptr;
  ptr_t rd_ptr;
  cnt_t count;                     // Entries held
  logic wr_ok;
  logic rd_ok;

  // Pointer step with wrap, depth need not be a power of two
  function automatic ptr_t ptr_inc(input ptr_t ptr);
    ptr_inc = (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr_ok = we_i & ~full_o;   // Drop writes when full
  assign rd_ok = re_i & ~empty_o;  // Ignore reads when empty

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (clr_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_ok) wr_ptr <= ptr_inc(wr_ptr);
      if (rd_ok) rd_ptr <= ptr_inc(rd_ptr);

      // Read plus write keeps the count
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_ok) mem[wr_ptr] <= d_i;
  end

  assign q_o           = mem[rd_ptr];
  assign empty_o       = (count == '0);
  assign full_o        = (count == cnt_t'(DEPTH));
  assign almost_full_o = (count >= cnt_t'(ALMOST_FULL));

endmodule

`default_nettype wire

// ==== source/imem_region_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_region_check (
  input  imem_bus_pkg::addr_t pc_i,
  input  imem_bus_pkg::addr_t pma_adr_i  [imem_bus_pkg::REGION_CNT],
  input  imem_bus_pkg::addr_t pma_mask_i [imem_bus_pkg::REGION_CNT],
  input  logic                pma_exec_i [imem_bus_pkg::REGION_CNT],
  output logic                misaligned_o,
  output logic                fault_o        // Any reason not to fetch
);

  logic [imem_bus_pkg::REGION_CNT-1:0] hit;      // PC inside region n
  logic [imem_bus_pkg::REGION_CNT-1:0] exec_hit; // Inside and executable

  ////////////////////////////////////////////////////////////////////////////
  // Alignment
  ////////////////////////////////////////////////////////////////////////////

  // Word fetch only
  assign misaligned_o = |pc_i[imem_bus_pkg::WORD_ALIGN_BITS-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Region lookup
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int n = 0; n < imem_bus_pkg::REGION_CNT; n++)
    begin
      // Masked compare against base
      hit[n]      = ((pc_i & pma_mask_i[n]) == pma_adr_i[n]);
      exec_hit[n] = hit[n] & pma_exec_i[n];
    end
  end

  // Regions may overlap
  // one executable hit is enough
  // Misalignment folded in so the top tests a single bit
  assign fault_o = misaligned_o | ~|exec_hit;

endmodule

`default_nettype wire

// ==== source/imem_wb_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_wb_fetch (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_i,      // Clean PC waiting, room in queue
  input  imem_bus_pkg::addr_t pc_i,
  output logic                done_o,     // Result valid this cycle
  output logic                bus_err_o,
  output imem_bus_pkg::word_t insn_o,

  // Wishbone classic, read only
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output imem_bus_pkg::addr_t wb_adr_o,
  input  imem_bus_pkg::word_t wb_dat_i,
  input  logic                wb_ack_i,
  input  logic                wb_err_i,

  input  logic                flush_i
);

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } state_t;

  state_t              state;
  imem_bus_pkg::addr_t adr_q;     // Address held for the whole cycle
  logic                discard;   // Flushed while on the bus
  logic                term;      // Slave ends the cycle

  assign term = (state == ST_BUSY) & (wb_ack_i | wb_err_i);

  ////////////////////////////////////////////////////////////////////////////
  // Master FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state   <= ST_IDLE;
      discard <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          discard <= 1'b0;
          if (req_i) state <= ST_BUSY;  // cyc/stb rise next cycle
        end
        ST_BUSY:
        begin
          if (term)
          begin
            state   <= ST_IDLE;         // Single access, no pipelining
            discard <= 1'b0;
          end
          else if (flush_i)
          begin
            discard <= 1'b1;            // Let it finish, drop the data
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Latched at the start
  // Low bits forced to a word boundary
  always_ff @(posedge clk_i)
  begin
    if (state == ST_IDLE && req_i)
      adr_q <= {pc_i[imem_bus_pkg::XLEN-1:imem_bus_pkg::WORD_ALIGN_BITS],
                {imem_bus_pkg::WORD_ALIGN_BITS{1'b0}}};
  end

  assign wb_cyc_o = (state == ST_BUSY);
  assign wb_stb_o = (state == ST_BUSY); // Classic, stb tracks cyc
  assign wb_adr_o = adr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////////////////////

  // A flush on the ack edge also drops the result
  assign done_o    = term & ~discard & ~flush_i;
  assign bus_err_o = wb_err_i;
  assign insn_o    = wb_err_i ? '0 : wb_dat_i;  // No data on error

endmodule

`default_nettype wire

// ==== source/imem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_ctrl (
  input  logic                clk_i,
  input  logic                rst_n_i,

  // CPU side
  input  imem_bus_pkg::addr_t nxt_pc_i,
  output logic                stall_nxt_pc_o,
  input  logic                stall_i,
  input  logic                flush_i,
  output imem_bus_pkg::addr_t parcel_pc_o,
  output imem_bus_pkg::word_t parcel_o,
  output logic                parcel_valid_o,
  output logic                misaligned_o,
  output logic                err_o,

  // Attribute regions
  input  imem_bus_pkg::addr_t pma_adr_i  [imem_bus_pkg::REGION_CNT],
  input  imem_bus_pkg::addr_t pma_mask_i [imem_bus_pkg::REGION_CNT],
  input  logic                pma_exec_i [imem_bus_pkg::REGION_CNT],

  // Wishbone classic
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output imem_bus_pkg::addr_t wb_adr_o,
  input  imem_bus_pkg::word_t wb_dat_i,
  input  logic                wb_ack_i,
  input  logic                wb_err_i
);

  imem_bus_pkg::addr_t     pc_head;       // Oldest buffered PC
  logic                    pc_empty;
  logic                    pc_full;
  logic                    pc_pop;
  logic                    head_misaligned;
  logic                    head_fault;
  logic                    fault_wr;      // Fault parcel, no bus cycle
  logic                    fetch_req;
  logic                    fetch_done;
  logic                    fetch_err;
  imem_bus_pkg::word_t     fetch_insn;
  imem_fetch_pkg::parcel_t parcel_d;
  imem_fetch_pkg::parcel_t pq_head;       // Oldest queued parcel
  logic                    pq_we;
  logic                    pq_re;
  logic                    pq_empty;
  logic                    pq_full;
  logic                    pq_almost_full;

  ////////////////////////////////////////////////////////////////////////////
  // Next-PC buffer
  ////////////////////////////////////////////////////////////////////////////

  imem_fifo #(
    .payload_t   ( imem_bus_pkg::addr_t         ),
    .DEPTH       ( imem_fetch_pkg::PC_BUF_DEPTH ),
    .ALMOST_FULL ( imem_fetch_pkg::PC_BUF_DEPTH )
  ) pc_buf (
    .clk_i         ( clk_i           ),
    .rst_n_i       ( rst_n_i         ),
    .clr_i         ( flush_i         ),
    .we_i          ( ~stall_nxt_pc_o ),
    .re_i          ( pc_pop          ),
    .d_i           ( nxt_pc_i        ),
    .q_o           ( pc_head         ),
    .empty_o       ( pc_empty        ),
    .full_o        ( pc_full         ),
    .almost_full_o (                 )
  );

  // Buffer full or CPU not draining parcels
  assign stall_nxt_pc_o = pc_full | pq_almost_full;

  ////////////////////////////////////////////////////////////////////////////
  // Checks and fetch
  ////////////////////////////////////////////////////////////////////////////

  imem_region_check region_chk (
    .pc_i         ( pc_head         ),
    .pma_adr_i    ( pma_adr_i       ),
    .pma_mask_i   ( pma_mask_i      ),
    .pma_exec_i   ( pma_exec_i      ),
    .misaligned_o ( head_misaligned ),
    .fault_o      ( head_fault      )
  );

  assign fault_wr  = ~pc_empty & head_fault & ~pq_full;
  // No new cycle on a flush edge as that PC is gone
  assign fetch_req = ~pc_empty & ~head_fault & ~pq_full & ~flush_i;

  imem_wb_fetch fetch (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .req_i     ( fetch_req  ),
    .pc_i      ( pc_head    ),
    .done_o    ( fetch_done ),
    .bus_err_o ( fetch_err  ),
    .insn_o    ( fetch_insn ),
    .wb_cyc_o  ( wb_cyc_o   ),
    .wb_stb_o  ( wb_stb_o   ),
    .wb_adr_o  ( wb_adr_o   ),
    .wb_dat_i  ( wb_dat_i   ),
    .wb_ack_i  ( wb_ack_i   ),
    .wb_err_i  ( wb_err_i   ),
    .flush_i   ( flush_i    )
  );

  // Head stays put on the bus and leaves with its parcel
  assign pc_pop = fault_wr | fetch_done;

  ////////////////////////////////////////////////////////////////////////////
  // Parcel queue
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    parcel_d.pc         = fetch_done ? wb_adr_o : pc_head;  // PC rides with the cycle
    parcel_d.insn       = fetch_done ? fetch_insn : '0;
    parcel_d.misaligned = ~fetch_done & head_misaligned;
    parcel_d.error      = fetch_done ? fetch_err : 1'b1;    // Fault path always errs
  end

  assign pq_we = fault_wr | fetch_done;
  assign pq_re = parcel_valid_o & ~stall_i;

  imem_fifo #(
    .payload_t   ( imem_fetch_pkg::parcel_t             ),
    .DEPTH       ( imem_fetch_pkg::PARCEL_Q_DEPTH       ),
    .ALMOST_FULL ( imem_fetch_pkg::PARCEL_Q_ALMOST_FULL )
  ) parcel_q (
    .clk_i         ( clk_i          ),
    .rst_n_i       ( rst_n_i        ),
    .clr_i         ( flush_i        ),
    .we_i          ( pq_we          ),
    .re_i          ( pq_re          ),
    .d_i           ( parcel_d       ),
    .q_o           ( pq_head        ),
    .empty_o       ( pq_empty       ),
    .full_o        ( pq_full        ),
    .almost_full_o ( pq_almost_full )
  );

  // Flags to the CPU only meaningful with a parcel
  assign parcel_valid_o = ~pq_empty;
  assign parcel_pc_o    = pq_head.pc;
  assign parcel_o       = pq_head.insn;
  assign misaligned_o   = pq_head.misaligned & parcel_valid_o;
  assign err_o          = pq_head.error & parcel_valid_o;

endmodule

`default_nettype wire

// ==== bench/imem_ctrl_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_ctrl_assertions (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                wb_cyc_o,
  input logic                wb_stb_o,
  input imem_bus_pkg::addr_t wb_adr_o,
  input logic                wb_ack_i,
  input logic                wb_err_i,
  input logic                parcel_valid_o,
  input logic                stall_nxt_pc_o
);

  // Cycle and strobe held together until the slave ends the cycle
  a_cyc_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wb_cyc_o && !wb_ack_i && !wb_err_i) |=> (wb_cyc_o && wb_stb_o))
    else $error("wb_cyc_o or wb_stb_o dropped before ack or err");

  // Address held through wait states
  a_adr_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wb_cyc_o && $past(wb_cyc_o)) |-> $stable(wb_adr_o))
    else $error("wb_adr_o changed within a bus cycle");

  // Quiet outputs in reset
  a_reset_quiet : assert property (@(posedge clk_i)
    !rst_n_i |-> (!parcel_valid_o && !stall_nxt_pc_o && !wb_cyc_o))
    else $error("Outputs active during reset");

endmodule

bind imem_ctrl imem_ctrl_assertions u_assert (
  .clk_i          ( clk_i          ),
  .rst_n_i        ( rst_n_i        ),
  .wb_cyc_o       ( wb_cyc_o       ),
  .wb_stb_o       ( wb_stb_o       ),
  .wb_adr_o       ( wb_adr_o       ),
  .wb_ack_i       ( wb_ack_i       ),
  .wb_err_i       ( wb_err_i       ),
  .parcel_valid_o ( parcel_valid_o ),
  .stall_nxt_pc_o ( stall_nxt_pc_o )
);

`default_nettype wire

// ==== bench/imem_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_ctrl_tb;

  localparam int ROWS = 12;                         // Stimulus table length
  localparam imem_bus_pkg::word_t SLAVE_XOR = 32'h5a5a_0000;

  logic                clk_i;
  logic                rst_n_i;
  imem_bus_pkg::addr_t nxt_pc_i;
  logic                stall_nxt_pc_o;
  logic                stall_i;
  logic                flush_i;
  imem_bus_pkg::addr_t parcel_pc_o;
  imem_bus_pkg::word_t parcel_o;
  logic                parcel_valid_o;
  logic                misaligned_o;
  logic                err_o;
  imem_bus_pkg::addr_t pma_adr  [imem_bus_pkg::REGION_CNT];
  imem_bus_pkg::addr_t pma_mask [imem_bus_pkg::REGION_CNT];
  logic                pma_exec [imem_bus_pkg::REGION_CNT];
  logic                wb_cyc_o;
  logic                wb_stb_o;
  imem_bus_pkg::addr_t wb_adr_o;
  imem_bus_pkg::word_t wb_dat_i;
  logic                wb_ack_i;
  logic                wb_err_i;

  // Stimulus table with expected columns from the fetch rules
  imem_bus_pkg::addr_t row_pc   [ROWS];
  imem_bus_pkg::word_t row_insn [ROWS];
  logic                row_mis  [ROWS];
  logic                row_err  [ROWS];

  int   exp_q[$];       // Table rows accepted and not yet consumed
  int   cur_row;        // Row on nxt_pc_i
  int   checked;        // Parcels compared so far
  logic s_stall_nxt;    // Last negedge samples
  logic s_valid;
  logic s_cyc;

  imem_ctrl uut (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .nxt_pc_i       ( nxt_pc_i       ),
    .stall_nxt_pc_o ( stall_nxt_pc_o ),
    .stall_i        ( stall_i        ),
    .flush_i        ( flush_i        ),
    .parcel_pc_o    ( parcel_pc_o    ),
    .parcel_o       ( parcel_o       ),
    .parcel_valid_o ( parcel_valid_o ),
    .misaligned_o   ( misaligned_o   ),
    .err_o          ( err_o          ),
    .pma_adr_i      ( pma_adr        ),
    .pma_mask_i     ( pma_mask       ),
    .pma_exec_i     ( pma_exec       ),
    .wb_cyc_o       ( wb_cyc_o       ),
    .wb_stb_o       ( wb_stb_o       ),
    .wb_adr_o       ( wb_adr_o       ),
    .wb_dat_i       ( wb_dat_i       ),
    .wb_ack_i       ( wb_ack_i       ),
    .wb_err_i       ( wb_err_i       )
  );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;                      // 4 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_addr(input string name, input imem_bus_pkg::addr_t got,
                            input imem_bus_pkg::addr_t exp);
    if (got !== exp)
      abort_run($sformatf("** Error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_word(input string name, input imem_bus_pkg::word_t got,
                            input imem_bus_pkg::word_t exp);
    if (got !== exp)
      abort_run($sformatf("** Error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("** Error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // Expected parcel for one PC from the alignment, region and slave rules
  task automatic expect_fetch(input imem_bus_pkg::addr_t pc, output imem_bus_pkg::word_t insn,
                              output logic mis, output logic err);
    logic exec_ok;
    exec_ok = 1'b0;
    for (int n = 0; n < imem_bus_pkg::REGION_CNT; n++)
      if (((pc & pma_mask[n]) == pma_adr[n]) && pma_exec[n]) exec_ok = 1'b1;
    mis  = |pc[imem_bus_pkg::WORD_ALIGN_BITS-1:0];
    insn = '0;
    err  = 1'b1;                                    // Any fault path
    if (!mis && exec_ok && !pc[12])
    begin
      insn = pc ^ SLAVE_XOR;                        // Slave data
      err  = 1'b0;
    end
  endtask

  // Sample at negedge and drive 1 ns after posedge
  task automatic step();
    logic acc;
    logic con;
    int   row;
    @(negedge clk_i);
    s_stall_nxt = stall_nxt_pc_o;
    s_valid     = parcel_valid_o;
    s_cyc       = wb_cyc_o;
    acc = rst_n_i && !flush_i && !stall_nxt_pc_o;   // PC taken this edge
    con = rst_n_i && !flush_i && parcel_valid_o && !stall_i;
    if (flush_i) exp_q.delete();
    if (con)
    begin
      if (exp_q.size() == 0) abort_run("A parcel was presented with no PC outstanding");
      row = exp_q.pop_front();
      check_addr("parcel_pc_o", parcel_pc_o, row_pc[row]);
      check_word("parcel_o", parcel_o, row_insn[row]);
      check_flag("misaligned_o", misaligned_o, row_mis[row]);
      check_flag("err_o", err_o, row_err[row]);
      checked++;
    end
    if (acc) exp_q.push_back(cur_row);
    @(posedge clk_i);
    #1;
    if (acc)
    begin
      cur_row  = (cur_row + 1) % ROWS;
      nxt_pc_i = row_pc[cur_row];
    end
  endtask

  // Run until enough parcels are compared under random CPU stall
  task automatic stream_parcels(input int count, input string phase);
    int target;
    int tmo;
    target = checked + count;
    tmo    = 0;
    while (checked < target)
    begin
      stall_i = ($urandom % 4 == 0);
      step();
      tmo++;
      if (tmo > 4000) abort_run({"Timeout waiting for parcels in phase ", phase});
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone slave with 0 to 3 wait states
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : slave
    logic active;
    int   waits;
    active   = 1'b0;
    waits    = 0;
    wb_ack_i = 1'b0;
    wb_err_i = 1'b0;
    wb_dat_i = '0;
    forever
    begin
      @(posedge clk_i);
      #1;
      if (wb_ack_i || wb_err_i)
      begin
        wb_ack_i = 1'b0;                            // Cycle ended at this edge
        wb_err_i = 1'b0;
        active   = 1'b0;
      end
      else if (wb_cyc_o && wb_stb_o)
      begin
        if (!active)
        begin
          active = 1'b1;
          waits  = $urandom % 4;
          if ((wb_adr_o & pma_mask[0]) != pma_adr[0])
            abort_run("A bus cycle started for a PC that must not be fetched");
        end
        if (waits == 0)
        begin
          if (wb_adr_o[12]) wb_err_i = 1'b1;        // Bit 12 marks a bad word
          else
          begin
            wb_ack_i = 1'b1;
            wb_dat_i = wb_adr_o ^ SLAVE_XOR;
          end
        end
        else waits--;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : main
    int tmo;
    void'($urandom(32'h21bd3f0b));
    rst_n_i  = 1'b0;
    stall_i  = 1'b0;
    flush_i  = 1'b0;
    checked  = 0;
    cur_row  = 0;
    pma_adr[0]  = 32'h0000_0000;                    // Executable
    pma_mask[0] = 32'hffff_0000;
    pma_exec[0] = 1'b1;
    pma_adr[1]  = 32'h0001_0000;                    // Not executable
    pma_mask[1] = 32'hffff_0000;
    pma_exec[1] = 1'b0;

    row_pc[0]  = 32'h0000_0000;
    row_pc[1]  = 32'h0000_0004;
    row_pc[2]  = 32'h0000_0010;
    row_pc[3]  = 32'h0000_0102;                     // Misaligned
    row_pc[4]  = 32'h0000_0008;
    row_pc[5]  = 32'h0001_0000;                     // Region 1
    row_pc[6]  = 32'h0002_0040;                     // No region
    row_pc[7]  = 32'h0000_1000;                     // Bus error
    row_pc[8]  = 32'h0000_0ffc;
    row_pc[9]  = 32'h0001_0001;                     // Misaligned and not exec
    row_pc[10] = 32'h0000_2004;
    row_pc[11] = 32'h0000_3008;                     // Bus error
    for (int i = 0; i < ROWS; i++)
      expect_fetch(row_pc[i], row_insn[i], row_mis[i], row_err[i]);
    nxt_pc_i = row_pc[0];

    repeat (5) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    stream_parcels(3 * ROWS, "stream");             // In order with all flag kinds

    // Stalled CPU fills the queue
    stall_i = 1'b1;
    tmo     = 0;
    s_stall_nxt = 1'b0;
    while (!s_stall_nxt)
    begin
      step();
      tmo++;
      if (tmo > 200) abort_run("Timeout waiting for stall_nxt_pc_o under CPU stall");
    end
    repeat (30) step();
    check_flag("stall_nxt_pc_o", s_stall_nxt, 1'b1); // Queue still at the threshold
    stream_parcels(2 * ROWS, "release");

    // Flush with parcels pending and a cycle on the bus
    stall_i = 1'b1;
    tmo     = 0;
    s_valid = 1'b0;
    s_cyc   = 1'b0;
    while (!(s_valid && s_cyc))
    begin
      step();
      tmo++;
      if (tmo > 200) abort_run("Timeout waiting for a bus cycle with parcels pending");
    end
    flush_i = 1'b1;
    step();
    flush_i = 1'b0;
    step();
    check_flag("parcel_valid_o", s_valid, 1'b0);    // Queue emptied
    check_flag("stall_nxt_pc_o", s_stall_nxt, 1'b0); // Both buffers empty
    stream_parcels(3 * ROWS, "after flush");

    stall_i = 1'b1;
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== imem_ctrl.f ====
source/imem_bus_pkg.sv
source/imem_fetch_pkg.sv
source/imem_fifo.sv
source/imem_region_check.sv
source/imem_wb_fetch.sv
source/imem_ctrl.sv
bench/imem_ctrl_assertions.sv
bench/imem_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the imem_ctrl testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f imem_ctrl.f --top-module imem_ctrl_tb \
  -Mdir obj_dir -o imem_ctrl_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/imem_ctrl_sim > sim.log 2>&1 || true
cat sim.log

# Verdict from the log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log \
  || { echo "FAIL: run ended early"; exit 1; }
echo "PASS"
exit 0
